// ==== build.sh ====
#!/usr/bin/env bash
# build the serial link testbench with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert \
  --top-module serialLinkTb --Mdir build/obj -o serialLinkSim \
  -f serialLink.f

./build/obj/serialLinkSim | tee build/sim.log

if grep -qx "Regression passed" build/sim.log; then
  echo "simulation log reports a pass"
else
  echo "simulation log reports a failure"
  exit 1
fi

// ==== dv/serialLinkChecker.sv ====
// monitor: word order model across the link and wishbone read data comparison
`default_nettype none
`include "serialLink_defs.svh"

module serialLinkChecker (
  input  wire logic                   clock,
  input  wire logic                   resetQ,
  input  wire logic                   cyc,
  input  wire logic                   stb,
  input  wire logic                   we,
  input  wire logic [1:0]             adr,
  input  wire logic [`LINK_WIDTH-1:0] wbDatW,
  input  wire logic                   ack,
  input  wire logic [`LINK_WIDTH-1:0] wbDatR,
  input  wire logic                   holdOff,      // a data write must not complete now
  input  wire logic                   statusCheck,  // compare the next status read
  input  wire logic [`LINK_WIDTH-1:0] statusMask,
  input  wire logic [`LINK_WIDTH-1:0] statusExp,
  output int                          valueErrors,
  output int                          otherErrors
);
  logic [`LINK_WIDTH-1:0] model [$];  // words written and not yet read back
  logic [`LINK_WIDTH-1:0] expected;
  logic                   lastReq;    // bus fields from the edge that accepted the access
  logic                   lastWe;
  logic [1:0]             lastAdr;
  logic [`LINK_WIDTH-1:0] lastDatW;
  logic                   lastHoldOff;
  logic                   lastStatusCheck;
  logic [`LINK_WIDTH-1:0] lastMask;
  logic [`LINK_WIDTH-1:0] lastExp;

  // ack seen here is the pre-edge value, so it belongs to the access captured last edge
  always @(posedge clock) begin
    if (resetQ) begin
      valueErrors = 0;
      otherErrors = 0;
      model.delete();
    end else if (ack && lastReq) begin
      if (lastWe && lastAdr == `ADDR_DATA) begin
        if (lastHoldOff) begin
          otherErrors = otherErrors + 1;
          $display("%0t: a data write was acked while the FIFO was full", $time);
        end
        model.push_back(lastDatW);
      end else if (!lastWe && lastAdr == `ADDR_RXDATA) begin
        if (model.size() == 0) begin
          otherErrors = otherErrors + 1;
          $display("%0t: a word was read back that was never written", $time);
        end else begin
          expected = model.pop_front();
          if (wbDatR !== expected) begin
            valueErrors = valueErrors + 1;
            $display("FAIL %0t wbDatR expected %h actual %h", $time, expected, wbDatR);
          end
        end
      end else if (!lastWe && lastAdr == `ADDR_STATUS && lastStatusCheck) begin
        if ((wbDatR & lastMask) !== lastExp) begin  // only the fields under test
          valueErrors = valueErrors + 1;
          $display("FAIL %0t wbDatR expected %h actual %h", $time, lastExp,
                   wbDatR & lastMask);
        end
      end
    end
    lastReq         = cyc && stb;
    lastWe          = we;
    lastAdr         = adr;
    lastDatW        = wbDatW;
    lastHoldOff     = holdOff;
    lastStatusCheck = statusCheck;
    lastMask        = statusMask;
    lastExp         = statusExp;
  end

endmodule

`default_nettype wire

// ==== dv/serialLinkTb.sv ====
// testbench top: clock, reset, delayed loopback, wishbone driver, test sequence, timeout
`default_nettype none
`include "serialLink_defs.svh"

module serialLinkTb;
  localparam int NumPat     = 19;                   // words in the pattern file
  localparam int PatIdxW    = $clog2(NumPat);
  localparam int Batch      = `FIFO_DEPTH + 2;      // queued + in flight + held
  localparam int HoldWords  = 5;
  localparam int HoldCycles = 60;
  localparam int WordBudget = `LINK_WIDTH * 2 * 10 + 50;
  localparam int CycleLimit = (1 + NumPat + Batch + HoldWords) * WordBudget;

  logic                   clock;
  logic                   resetQ;
  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [1:0]             adr;
  logic [`LINK_WIDTH-1:0] wbDatW;
  logic                   ack;
  logic [`LINK_WIDTH-1:0] wbDatR;
  logic [1:0]             txWires;
  logic                   txAck;
  logic [1:0]             rxWires;
  logic                   rxAck;
  logic [`LINK_WIDTH-1:0] patterns [NumPat];
  logic [7:0]             wirePipe;    // four stages of the wire pair
  logic [3:0]             ackPipe;
  logic [1:0]             wireSel;     // loopback delay minus one
  logic [1:0]             ackSel;
  logic                   holdAck;     // forces txAck low
  logic                   holdOff;
  logic                   statusCheck;
  logic [`LINK_WIDTH-1:0] statusMask;
  logic [`LINK_WIDTH-1:0] statusExp;
  logic [`LINK_WIDTH-1:0] rdData;
  logic [`LINK_WIDTH-1:0] allMask;
  integer                 seed;
  int                     cycles = 0;
  int                     valueErrors;
  int                     otherErrors;
  int                     linkErrors;

  serialLinkTop i_dut (
    .clock, .resetQ, .cyc, .stb, .we, .adr, .wbDatW, .ack, .wbDatR,
    .txWires, .txAck, .rxWires, .rxAck
  );

  serialLinkChecker i_checker (
    .clock, .resetQ, .cyc, .stb, .we, .adr, .wbDatW, .ack, .wbDatR,
    .holdOff, .statusCheck, .statusMask, .statusExp, .valueErrors, .otherErrors
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // loopback, shifted on the falling edge like every other input
  always @(negedge clock) begin
    if (resetQ) begin
      wirePipe <= '0;
      ackPipe  <= '0;
    end else begin
      wirePipe <= {wirePipe[5:0], txWires};
      ackPipe  <= {ackPipe[2:0], rxAck};
    end
  end

  assign rxWires = wirePipe[{wireSel, 1'b0} +: 2];
  assign txAck   = holdAck ? 1'b0 : ackPipe[ackSel];

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("timeout: the link did not finish within %0d cycles", CycleLimit);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [`LINK_WIDTH-1:0] patternAt(input int i);
    return patterns[PatIdxW'(i % NumPat)];
  endfunction

  // status word per the register map
  function automatic logic [`LINK_WIDTH-1:0] makeStatus(input logic rxv, input logic txb,
                                                         input logic full, input int cnt);
    logic [`LINK_WIDTH-1:0] s;
    s = '0;
    s[`STAT_RXVALID]  = rxv;
    s[`STAT_TXBUSY]   = txb;
    s[`STAT_FIFOFULL] = full;
    s[`STAT_COUNT_LSB +: `FIFO_CNT_WIDTH] = cnt[`FIFO_CNT_WIDTH-1:0];
    return s;
  endfunction

  task automatic busStart(input logic isWrite, input logic [1:0] addr,
                          input logic [`LINK_WIDTH-1:0] data);
    @(negedge clock);
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = isWrite;
    adr    = addr;
    wbDatW = data;
  endtask

  task automatic busFinish(output logic [`LINK_WIDTH-1:0] data);
    do @(negedge clock); while (!ack);  // back-pressure shows as a late ack
    data = wbDatR;
    cyc  = 1'b0;
    stb  = 1'b0;
    we   = 1'b0;
  endtask

  task automatic busWrite(input logic [1:0] addr, input logic [`LINK_WIDTH-1:0] data);
    logic [`LINK_WIDTH-1:0] unused;
    busStart(1'b1, addr, data);
    busFinish(unused);
  endtask

  task automatic busRead(input logic [1:0] addr, output logic [`LINK_WIDTH-1:0] data);
    busStart(1'b0, addr, '0);
    busFinish(data);
  endtask

  task automatic waitStatusSet(input logic [`LINK_WIDTH-1:0] mask);
    logic [`LINK_WIDTH-1:0] s;
    do busRead(`ADDR_STATUS, s); while ((s & mask) == '0);
  endtask

  task automatic readWord();
    waitStatusSet(makeStatus(1'b1, 1'b0, 1'b0, 0));
    busRead(`ADDR_RXDATA, rdData);   // checker compares against its model
  endtask

  task automatic checkStatus(input logic [`LINK_WIDTH-1:0] exp);
    statusMask  = allMask;
    statusExp   = exp;
    statusCheck = 1'b1;
    busRead(`ADDR_STATUS, rdData);
    statusCheck = 1'b0;
  endtask

  // link wire levels seen from the host side
  task automatic checkLink(input logic [1:0] expWires, input logic expAck);
    if (txWires !== expWires) begin
      linkErrors = linkErrors + 1;
      $display("FAIL %0t txWires expected %b actual %b", $time, expWires, txWires);
    end
    if (rxAck !== expAck) begin
      linkErrors = linkErrors + 1;
      $display("FAIL %0t rxAck expected %b actual %b", $time, expAck, rxAck);
    end
  endtask

  initial begin
    seed        = 32'h82149f9f;
    wireSel     = 2'($random(seed));
    ackSel      = 2'($random(seed));
    resetQ      = 1'b1;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = 2'd0;
    wbDatW      = '0;
    holdAck     = 1'b0;
    holdOff     = 1'b0;
    statusCheck = 1'b0;
    statusMask  = '0;
    statusExp   = '0;
    linkErrors  = 0;
    allMask     = makeStatus(1'b1, 1'b1, 1'b1, (1 << `FIFO_CNT_WIDTH) - 1);
    $readmemh("dv/serialLink_patterns.hex", patterns);
    $display("loopback delay: wires %0d, ack %0d cycles", wireSel + 1, ackSel + 1);
    repeat (2) @(posedge clock);
    @(negedge clock);
    resetQ = 1'b0;
    checkLink(2'b00, 1'b0);  // both link sides idle out of reset

    busWrite(`ADDR_DATA, patternAt(0));  // single word round trip
    readWord();

    // order, in batches the link can absorb without a read
    for (int base = 0; base < NumPat; base += Batch) begin
      for (int i = base; i < base + Batch && i < NumPat; i++) busWrite(`ADDR_DATA, patternAt(i));
      for (int i = base; i < base + Batch && i < NumPat; i++) readWord();
    end

    // fifo back-pressure, the first word sticks in the transmitter
    holdAck = 1'b1;
    busWrite(`ADDR_DATA, patternAt(0));
    waitStatusSet(makeStatus(1'b0, 1'b1, 1'b0, 0));
    for (int i = 1; i <= `FIFO_DEPTH; i++) busWrite(`ADDR_DATA, patternAt(i));
    checkStatus(makeStatus(1'b0, 1'b1, 1'b1, `FIFO_DEPTH));
    holdOff = 1'b1;
    busStart(1'b1, `ADDR_DATA, patternAt(`FIFO_DEPTH + 1));
    repeat (HoldCycles) @(negedge clock);
    holdOff = 1'b0;
    holdAck = 1'b0;
    busFinish(rdData);
    for (int i = 0; i < Batch; i++) readWord();

    // receive back-pressure: one held, one stalled mid word, rest queued
    for (int i = 0; i < HoldWords; i++) busWrite(`ADDR_DATA, patternAt(NumPat - 1 - i));
    waitStatusSet(makeStatus(1'b1, 1'b0, 1'b0, 0));
    repeat (HoldCycles) @(negedge clock);
    checkStatus(makeStatus(1'b1, 1'b1, 1'b0, HoldWords - 2));
    for (int i = 0; i < HoldWords; i++) readWord();

    repeat (20) @(negedge clock);  // last ack round trip
    checkStatus(makeStatus(1'b0, 1'b0, 1'b0, 0));
    checkLink(txWires, ^txWires);  // settled link, ack equals wire parity

    @(negedge clock);
    $display("checks done: %0d value errors, %0d other errors, %0d link errors",
             valueErrors, otherErrors, linkErrors);
    if (valueErrors + otherErrors + linkErrors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/serialLink_patterns.hex ====
// one 16-bit hex word per line, written to ADDR_DATA and expected back in order
0000
FFFF
A5A5
5A5A
0001
8000
1234
FEDC
00FF
FF00
0F0F
F0F0
7FFF
FFFE
3C3C
C3C3
2468
9BDF
5555

// ==== serialLink.f ====
+incdir+src
src/serialLinkPkg.sv
src/wbRegPort.sv
src/wordFifo.sv
src/serialTx.sv
src/serialRx.sv
src/serialLinkTop.sv
dv/serialLinkChecker.sv
dv/serialLinkTb.sv

// ==== src/serialLinkPkg.sv ====
// shared enums: wishbone register decode, transmit and receive states
`default_nettype none
`include "serialLink_defs.svh"

package serialLinkPkg;

  // register select, decoded from the two wishbone address bits
  typedef enum logic [1:0] {
    regData   = `ADDR_DATA,
    regStatus = `ADDR_STATUS,
    regRxData = `ADDR_RXDATA,
    regNone   = 2'd3          // unmapped, acked and ignored
  } regAddrE;

  // serializer FSM
  typedef enum logic [1:0] {
    txIdle,  // waiting on a fifo word
    txSend,  // one wire transition per returned ack
    txWait   // last bit out, waiting for its ack
  } txStateE;

  // deserializer FSM
  typedef enum logic {
    rxCollect,  // decoding wire transitions
    rxHold      // word complete, ack frozen until the host pops
  } rxStateE;

endpackage

`default_nettype wire

// ==== src/serialLinkTop.sv ====
// link top: wishbone port, transmit fifo, serializer and deserializer
`default_nettype none
`include "serialLink_defs.svh"

module serialLinkTop (
  input  wire logic                   clock,
  input  wire logic                   resetQ,
  // wishbone classic slave
  input  wire logic                   cyc,
  input  wire logic                   stb,
  input  wire logic                   we,
  input  wire logic [1:0]             adr,
  input  wire logic [`LINK_WIDTH-1:0] wbDatW,
  output logic                        ack,
  output logic [`LINK_WIDTH-1:0]      wbDatR,
  // serial link
  output logic [1:0]                  txWires,
  input  wire logic                   txAck,
  input  wire logic [1:0]             rxWires,
  output logic                        rxAck
);
  logic                       push;
  logic [`LINK_WIDTH-1:0]     pushData;
  logic                       fifoFull;
  logic [`FIFO_CNT_WIDTH-1:0] fifoCount;
  logic                       popValid;
  logic [`LINK_WIDTH-1:0]     popData;
  logic                       popReady;
  logic                       txBusy;
  logic                       rxValid;
  logic [`LINK_WIDTH-1:0]     rxData;
  logic                       rxPop;

  wbRegPort i_wbRegPort (
    .clock, .resetQ, .cyc, .stb, .we, .adr, .wbDatW, .ack, .wbDatR,
    .push, .pushData, .fifoFull, .fifoCount, .txBusy,
    .rxValid, .rxData, .rxPop
  );

  wordFifo #(.Depth(`FIFO_DEPTH)) i_wordFifo (
    .clock, .resetQ, .push, .pushData,
    .full(fifoFull), .count(fifoCount),   // status bits for the host
    .popValid, .popData, .popReady
  );

  serialTx i_serialTx (
    .clock, .resetQ, .popValid, .popData, .popReady, .txWires, .txBusy, .txAck
  );

  serialRx i_serialRx (
    .clock, .resetQ, .rxWires, .rxAck, .rxValid, .rxData, .rxPop
  );

endmodule

`default_nettype wire

// ==== src/serialLink_defs.svh ====
// link word width, fifo depth, wishbone register map and status bit positions
`ifndef SERIALLINK_DEFS_SVH
`define SERIALLINK_DEFS_SVH

// bits per serialized word
`define LINK_WIDTH 16

// default transmit fifo depth
`define FIFO_DEPTH 8
`define FIFO_CNT_WIDTH ($clog2(`FIFO_DEPTH + 1))  // count holds 0..depth inclusive

// wishbone word addresses
`define ADDR_DATA   2'd0  // write pushes a tx word
`define ADDR_STATUS 2'd1  // read only
`define ADDR_RXDATA 2'd2  // read pops the held rx word

// status word layout
`define STAT_RXVALID   0
`define STAT_TXBUSY    1
`define STAT_FIFOFULL  2
`define STAT_COUNT_LSB 8  // fifo count sits from here upward

`endif

// ==== src/serialRx.sv ====
// two-wire transition decoder, word assembler and single-entry holding register
`default_nettype none
`include "serialLink_defs.svh"

module serialRx (
  input  wire logic                   clock,
  input  wire logic                   resetQ,
  input  wire logic [1:0]             rxWires,   // async from the far transmitter
  output logic                        rxAck,
  output logic                        rxValid,
  output logic [`LINK_WIDTH-1:0]      rxData,
  input  wire logic                   rxPop
);
  import serialLinkPkg::*;

  localparam int CntW = $clog2(`LINK_WIDTH);

  rxStateE                state;
  logic [1:0]             wiresMeta;
  logic [1:0]             wiresSync;
  logic [1:0]             wiresSeen;   // last decoded wire levels
  logic [1:0]             edges;
  logic                   newBit;
  logic [`LINK_WIDTH-1:0] shiftReg;
  logic [CntW-1:0]        bitCnt;

  assign edges   = wiresSync ^ wiresSeen;
  assign newBit  = edges[1];                  // wire 1 toggled means a one
  assign rxValid = (state == rxHold);

  always_ff @(posedge clock) begin
    if (resetQ) begin
      wiresMeta <= 2'b00;
      wiresSync <= 2'b00;
      wiresSeen <= 2'b00;
      rxAck     <= 1'b0;
      bitCnt    <= '0;
      state     <= rxCollect;
    end else begin
      wiresMeta <= rxWires;
      wiresSync <= wiresMeta;
      case (state)
        rxCollect: begin
          if (edges != 2'b00) begin
            wiresSeen <= wiresSync;
            rxAck     <= ^wiresSync;         // ack level tracks wire parity
            shiftReg  <= {newBit, shiftReg[`LINK_WIDTH-1:1]};  // lsb arrives first
            bitCnt    <= bitCnt + 1'b1;
            if (bitCnt == CntW'(`LINK_WIDTH - 1)) begin
              rxData <= {newBit, shiftReg[`LINK_WIDTH-1:1]};
              bitCnt <= '0;
              state  <= rxHold;
            end
          end
        end
        default: begin  // rxHold, no ack so the far side stalls
          if (rxPop) state <= rxCollect;
        end
      endcase
    end
  end

  // one transition per bit, both wires moving at once is a broken link
  oneWireAtATime: assert property (@(posedge clock) disable iff (resetQ)
    !(&(wiresSync ^ $past(wiresSync))));

endmodule

`default_nettype wire

// ==== src/serialTx.sv ====
// two-wire transition-coded serializer with two flop ack synchronizer
`default_nettype none
`include "serialLink_defs.svh"

module serialTx (
  input  wire logic                   clock,
  input  wire logic                   resetQ,
  input  wire logic                   popValid,
  input  wire logic [`LINK_WIDTH-1:0] popData,
  output logic                        popReady,
  output logic [1:0]                  txWires,   // [1] toggles for a one, [0] for a zero
  output logic                        txBusy,
  input  wire logic                   txAck      // async from the far side
);
  import serialLinkPkg::*;

  localparam int CntW = $clog2(`LINK_WIDTH);

  txStateE                state;
  logic                   ackMeta;
  logic                   ackSync;
  logic                   ackMatch;   // far side has seen the latest transition
  logic [`LINK_WIDTH-1:0] shiftReg;   // bits still to send, lsb next
  logic [CntW-1:0]        bitCnt;

  always_ff @(posedge clock) begin
    if (resetQ) begin
      ackMeta <= 1'b0;
      ackSync <= 1'b0;
    end else begin
      ackMeta <= txAck;
      ackSync <= ackMeta;
    end
  end

  assign ackMatch = (ackSync == ^txWires);
  assign txBusy   = (state != txIdle);

  always_ff @(posedge clock) begin
    if (resetQ) begin
      state    <= txIdle;
      popReady <= 1'b0;
      txWires  <= 2'b00;
      bitCnt   <= '0;
    end else begin
      case (state)
        txIdle: begin
          if (popValid && popReady && ackMatch) begin
            // word latched here, the fifo head may move on
            txWires  <= txWires ^ {popData[0], !popData[0]};
            shiftReg <= popData >> 1;
            bitCnt   <= CntW'(1);
            popReady <= 1'b0;
            state    <= txSend;
          end else begin
            popReady <= 1'b1;
          end
        end
        txSend: begin
          if (ackMatch) begin
            txWires  <= txWires ^ {shiftReg[0], !shiftReg[0]};
            shiftReg <= shiftReg >> 1;
            bitCnt   <= bitCnt + 1'b1;
            if (bitCnt == CntW'(`LINK_WIDTH - 1)) state <= txWait;  // last bit gone
          end
        end
        default: begin  // txWait
          if (ackMatch) begin
            bitCnt   <= '0;
            popReady <= 1'b1;   // ready for the next word straight away
            state    <= txIdle;
          end
        end
      endcase
    end
  end

  // the synchronized ack round trip always separates two transitions
  wiresSettle: assert property (@(posedge clock) disable iff (resetQ)
    $changed(txWires) |=> $stable(txWires));

endmodule

`default_nettype wire

// ==== src/wbRegPort.sv ====
// wishbone classic slave: tx word push, status readback and rx word pop
`default_nettype none
`include "serialLink_defs.svh"

module wbRegPort (
  input  wire logic                       clock,
  input  wire logic                       resetQ,
  // wishbone classic slave
  input  wire logic                       cyc,
  input  wire logic                       stb,
  input  wire logic                       we,
  input  wire logic [1:0]                 adr,
  input  wire logic [`LINK_WIDTH-1:0]     wbDatW,
  output logic                            ack,
  output logic [`LINK_WIDTH-1:0]          wbDatR,
  // transmit fifo
  output logic                            push,
  output logic [`LINK_WIDTH-1:0]          pushData,
  input  wire logic                       fifoFull,
  input  wire logic [`FIFO_CNT_WIDTH-1:0] fifoCount,
  input  wire logic                       txBusy,
  // receive holding register
  input  wire logic                       rxValid,
  input  wire logic [`LINK_WIDTH-1:0]     rxData,
  output logic                            rxPop
);
  import serialLinkPkg::*;

  regAddrE                regSel;
  logic                   request;     // cycle open and not already acking
  logic                   ready;       // target can complete the access now
  logic                   accept;
  logic [`LINK_WIDTH-1:0] statusWord;

  always_comb begin
    case (adr)
      `ADDR_DATA:   regSel = regData;
      `ADDR_STATUS: regSel = regStatus;
      `ADDR_RXDATA: regSel = regRxData;
      default:      regSel = regNone;
    endcase
  end

  // back-pressure is a withheld ack
  always_comb begin
    ready = 1'b1;
    if (we && (regSel == regData)) ready = !fifoFull;     // no room yet
    if (!we && (regSel == regRxData)) ready = rxValid;    // nothing held yet
  end

  assign request  = cyc && stb && !ack;
  assign accept   = request && ready;
  assign push     = accept && we && (regSel == regData);
  assign pushData = wbDatW;
  assign rxPop    = accept && !we && (regSel == regRxData);  // frees the holding register

  always_comb begin
    statusWord = '0;
    statusWord[`STAT_RXVALID]  = rxValid;
    statusWord[`STAT_TXBUSY]   = txBusy;
    statusWord[`STAT_FIFOFULL] = fifoFull;
    statusWord[`STAT_COUNT_LSB +: `FIFO_CNT_WIDTH] = fifoCount;
  end

  // single cycle ack, the cycle after accept
  always_ff @(posedge clock) begin
    if (resetQ) begin
      ack <= 1'b0;
    end else begin
      ack <= accept;
    end
  end

  // read data lines up with ack
  always_ff @(posedge clock) begin
    if (accept && !we) begin
      case (regSel)
        regStatus: wbDatR <= statusWord;
        regRxData: wbDatR <= rxData;
        default:   wbDatR <= '0;  // reads of the data port return zero
      endcase
    end
  end

  // a stalled request stays on the bus until it is acked
  requestHeld: assert property (@(posedge clock) disable iff (resetQ)
    (request && !ready) |=> (cyc && stb));

endmodule

`default_nettype wire

// ==== src/wordFifo.sv ====
// circular word buffer with occupancy count, push and pop in the same cycle
`default_nettype none
`include "serialLink_defs.svh"

module wordFifo #(
  parameter int Depth = 8
) (
  input  wire logic                         clock,
  input  wire logic                         resetQ,
  input  wire logic                         push,
  input  wire logic [`LINK_WIDTH-1:0]       pushData,
  output logic                              full,
  output logic [$clog2(Depth + 1)-1:0]      count,
  output logic                              popValid,
  output logic [`LINK_WIDTH-1:0]            popData,
  input  wire logic                         popReady
);
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [`LINK_WIDTH-1:0] mem [Depth];
  logic [PtrW-1:0]        wrPtr;
  logic [PtrW-1:0]        rdPtr;
  logic                   doPop;

  assign full     = (count == CntW'(Depth));
  assign popValid = (count != '0);
  assign popData  = mem[rdPtr];        // head word straight from storage
  assign doPop    = popValid && popReady;

  // storage, no reset needed
  always_ff @(posedge clock) begin
    if (push) mem[wrPtr] <= pushData;
  end

  always_ff @(posedge clock) begin
    if (resetQ) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;  // wrap at depth
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({push, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // both or neither, occupancy unchanged
      endcase
    end
  end

  // producer must respect full over any sequence of pushes and pops
  countInRange: assert property (@(posedge clock) disable iff (resetQ)
    count <= CntW'(Depth));

endmodule

`default_nettype wire
